// ==== hdl/dp_alu_ops_pkg.sv ====
package dp_alu_ops_pkg;

  // --------------------
  // Opcode encodings
  localparam int op_width = 2;
  localparam logic [op_width-1:0] enc_add = 2'd0;
  localparam logic [op_width-1:0] enc_sub = 2'd1;
  localparam logic [op_width-1:0] enc_and = 2'd2;
  localparam logic [op_width-1:0] enc_max = 2'd3;

  // Max compares unsigned
  typedef enum logic [op_width-1:0] {
    op_add = enc_add,
    op_sub = enc_sub,
    op_and = enc_and,
    op_max = enc_max
  } alu_op_t;

  // --------------------
  // Result packer states
  localparam int pack_state_width = 2;

  typedef enum logic [pack_state_width-1:0] {
    pack_empty,
    pack_half,
    pack_full
  } pack_state_t;

endpackage

// ==== hdl/dp_vector_pkg.sv ====
package dp_vector_pkg;

  localparam int lane_width = 16;

  // One lane of operands
  typedef struct packed {
    logic [lane_width-1:0] x;
    logic [lane_width-1:0] y;
  } lane_t;

  // Input vector on clock
  typedef struct packed {
    dp_alu_ops_pkg::alu_op_t op;
    lane_t                   lane0;
    lane_t                   lane1;
  } vector_in_t;

  // Single lane item on clock2x
  typedef struct packed {
    dp_alu_ops_pkg::alu_op_t op;
    lane_t                   lane;
  } stream_item_t;

  // Result vector on clock
  typedef struct packed {
    logic [lane_width-1:0] res0;
    logic [lane_width-1:0] res1;
  } vector_out_t;

endpackage

// ==== hdl/vector_to_stream.sv ====
`timescale 1ns/1ps

module vector_to_stream (
  input  logic                        clock,
  input  logic                        clock2x,
  input  logic                        resetn,
  input  logic                        start,
  input  dp_vector_pkg::vector_in_t   in_data,
  input  logic                        in_valid,
  output logic                        in_stall,
  output dp_vector_pkg::stream_item_t item,
  output logic                        item_valid,
  input  logic                        item_stall,
  output logic                        start_2x
);
  import dp_vector_pkg::*;
  import dp_alu_ops_pkg::*;

  vector_in_t skid_data;
  logic       skid_valid;
  vector_in_t hold_data;
  logic       hold_valid;
  logic       hold_free;
  logic       hold_taken;
  logic       start_1x;

  logic       tick_2x;
  logic       tick_ref;
  logic       load_phase;

  alu_op_t    slot_op;
  lane_t      slot0;
  lane_t      slot1;
  logic       slot0_valid;
  logic       slot1_valid;
  logic       do_load;
  logic       do_shift;

  // --------------------
  // Skid and holding registers on clock

  // Holding register moves on once the 2x side has copied it
  assign hold_free = ~hold_valid | hold_taken;
  assign in_stall  = skid_valid;

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
    begin
      skid_valid <= 1'b0;
      hold_valid <= 1'b0;
      start_1x   <= 1'b0;
    end
    else
    begin
      start_1x <= start;
      if (start || hold_free)
        skid_valid <= 1'b0;
      else if (!skid_valid)
        skid_valid <= in_valid;
      if (start)
        hold_valid <= 1'b0;
      else if (hold_free)
        hold_valid <= in_valid | skid_valid;
    end
  end

  always_ff @(posedge clock)
  begin
    if (!skid_valid)
      skid_data <= in_data;
    if (hold_free)
      hold_data <= skid_valid ? skid_data : in_data;
  end

  // --------------------
  // Phase of clock2x within clock

  // High while the next clock2x edge falls mid-cycle of clock
  assign load_phase = (tick_ref != tick_2x);

  always_ff @(posedge clock2x or negedge resetn)
  begin
    if (!resetn)
      tick_2x <= 1'b0;
    else
      tick_2x <= ~tick_2x;
  end

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      tick_ref <= 1'b0;
    else
      tick_ref <= tick_2x;
  end

  // --------------------
  // Two-slot shift register on clock2x

  assign do_load  = load_phase & (~slot0_valid | (~item_stall & ~slot1_valid));
  assign do_shift = slot0_valid & ~item_stall & ~do_load;

  always_ff @(posedge clock2x or negedge resetn)
  begin
    if (!resetn)
    begin
      start_2x    <= 1'b0;
      slot0_valid <= 1'b0;
      slot1_valid <= 1'b0;
      hold_taken  <= 1'b0;
    end
    else
    begin
      start_2x <= start_1x;
      // Holding register is already flushed when a load meets start_2x
      if (do_load)
      begin
        slot0_valid <= hold_valid;
        slot1_valid <= hold_valid;
      end
      else if (start_2x)
      begin
        slot0_valid <= 1'b0;
        slot1_valid <= 1'b0;
      end
      else if (do_shift)
      begin
        slot0_valid <= slot1_valid;
        slot1_valid <= 1'b0;
      end
      if (load_phase)
        hold_taken <= do_load & hold_valid;
    end
  end

  always_ff @(posedge clock2x)
  begin
    if (do_load)
    begin
      slot_op <= hold_data.op;
      slot0   <= hold_data.lane0;
      slot1   <= hold_data.lane1;
    end
    else if (do_shift)
      slot0 <= slot1;
  end

  assign item       = '{op: slot_op, lane: slot0};
  assign item_valid = slot0_valid;

  item_held: assert property (@(posedge clock2x) disable iff (!resetn)
    item_valid && item_stall && !start_2x |=> item_valid && $stable(item));

endmodule

// ==== hdl/lane_alu.sv ====
`timescale 1ns/1ps

module lane_alu (
  input  logic                                  clock2x,
  input  logic                                  resetn,
  input  logic                                  start_2x,
  input  dp_vector_pkg::stream_item_t           item,
  input  logic                                  item_valid,
  output logic                                  item_stall,
  output logic [dp_vector_pkg::lane_width-1:0]  result,
  output logic                                  result_valid,
  input  logic                                  result_stall
);
  import dp_vector_pkg::*;
  import dp_alu_ops_pkg::*;

  logic [lane_width-1:0] alu_out;

  // Only a result that cannot leave blocks the input
  assign item_stall = result_valid & result_stall;

  always_comb
  begin
    case (item.op)
      op_add:  alu_out = item.lane.x + item.lane.y;
      op_sub:  alu_out = item.lane.x - item.lane.y;
      op_and:  alu_out = item.lane.x & item.lane.y;
      op_max:  alu_out = (item.lane.x > item.lane.y) ? item.lane.x : item.lane.y;
      default: alu_out = '0;
    endcase
  end

  // --------------------
  // Result register

  always_ff @(posedge clock2x or negedge resetn)
  begin
    if (!resetn)
      result_valid <= 1'b0;
    else if (start_2x)
      result_valid <= 1'b0;
    else if (!item_stall)
      result_valid <= item_valid;
  end

  always_ff @(posedge clock2x)
  begin
    if (!item_stall)
      result <= alu_out;
  end

  op_known: assert property (@(posedge clock2x) disable iff (!resetn)
    item_valid |-> !$isunknown(item.op));

endmodule

// ==== hdl/stream_to_vector.sv ====
`timescale 1ns/1ps

module stream_to_vector (
  input  logic                                  clock,
  input  logic                                  clock2x,
  input  logic                                  resetn,
  input  logic                                  start_2x,
  input  logic [dp_vector_pkg::lane_width-1:0]  result,
  input  logic                                  result_valid,
  output logic                                  result_stall,
  output dp_vector_pkg::vector_out_t            out_data,
  output logic                                  out_valid,
  input  logic                                  out_stall
);
  import dp_vector_pkg::*;
  import dp_alu_ops_pkg::*;

  pack_state_t           state;
  logic [lane_width-1:0] res0;
  logic [lane_width-1:0] res1;

  logic frame_1x;
  logic frame_seen;
  logic edge_next;
  logic out_free;
  logic take_full;
  logic take_half;
  logic accept;

  // --------------------
  // Clock edge detection on clock2x

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      frame_1x <= 1'b0;
    else
      frame_1x <= ~frame_1x;
  end

  always_ff @(posedge clock2x or negedge resetn)
  begin
    if (!resetn)
      frame_seen <= 1'b0;
    else
      frame_seen <= frame_1x;
  end

  // Next clock2x edge is also a clock edge
  assign edge_next = (frame_seen == frame_1x);

  // --------------------
  // Pair hand-off to the output register

  assign out_free  = ~out_valid | ~out_stall;
  assign take_full = edge_next & out_free & ~start_2x & (state == pack_full);
  // Second half arriving on a clock edge goes straight out
  assign take_half = edge_next & out_free & ~start_2x & (state == pack_half) & result_valid;

  assign result_stall = (state == pack_full) & ~take_full;
  assign accept       = result_valid & ~result_stall;

  always_ff @(posedge clock2x or negedge resetn)
  begin
    if (!resetn)
      state <= pack_empty;
    else if (start_2x)
      state <= pack_empty;
    else
    begin
      case (state)
        pack_empty: if (result_valid) state <= pack_half;
        pack_half:
        begin
          if (take_half)
            state <= pack_empty;
          else if (result_valid)
            state <= pack_full;
        end
        pack_full:  if (take_full) state <= result_valid ? pack_half : pack_empty;
        default:    state <= pack_empty;
      endcase
    end
  end

  always_ff @(posedge clock2x)
  begin
    if (accept)
    begin
      if (state == pack_half)
        res1 <= result;
      else
        res0 <= result;
    end
  end

  // --------------------
  // Output register on clock

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      out_valid <= 1'b0;
    else if (start_2x)
      out_valid <= 1'b0;
    else if (out_free)
      out_valid <= take_full | take_half;
  end

  always_ff @(posedge clock)
  begin
    if (take_full)
      out_data <= '{res0: res0, res1: res1};
    else if (take_half)
      out_data <= '{res0: res0, res1: result};
  end

  out_holds: assert property (@(posedge clock) disable iff (!resetn)
    out_valid && out_stall && !start_2x |=> out_valid && $stable(out_data));

endmodule

// ==== hdl/double_pumped_alu.sv ====
`timescale 1ns/1ps

module double_pumped_alu (
  input  logic                       clock,
  input  logic                       clock2x,
  input  logic                       resetn,
  input  logic                       start,
  input  dp_vector_pkg::vector_in_t  in_data,
  input  logic                       in_valid,
  output logic                       in_stall,
  output dp_vector_pkg::vector_out_t out_data,
  output logic                       out_valid,
  input  logic                       out_stall
);
  import dp_vector_pkg::*;

  stream_item_t          v2s_item;
  logic                  v2s_valid;
  logic                  alu_stall;
  logic                  start_2x;
  logic [lane_width-1:0] alu_result;
  logic                  alu_valid;
  logic                  s2v_stall;

  vector_to_stream u_v2s (
    .clock      (clock),
    .clock2x    (clock2x),
    .resetn     (resetn),
    .start      (start),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_stall   (in_stall),
    .item       (v2s_item),
    .item_valid (v2s_valid),
    .item_stall (alu_stall),
    .start_2x   (start_2x)
  );

  lane_alu u_alu (
    .clock2x      (clock2x),
    .resetn       (resetn),
    .start_2x     (start_2x),
    .item         (v2s_item),
    .item_valid   (v2s_valid),
    .item_stall   (alu_stall),
    .result       (alu_result),
    .result_valid (alu_valid),
    .result_stall (s2v_stall)
  );

  stream_to_vector u_s2v (
    .clock        (clock),
    .clock2x      (clock2x),
    .resetn       (resetn),
    .start_2x     (start_2x),
    .result       (alu_result),
    .result_valid (alu_valid),
    .result_stall (s2v_stall),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_stall    (out_stall)
  );

endmodule

// ==== test/tb_double_pumped_alu.sv ====
`timescale 1ns/1ps

module tb_double_pumped_alu;
  import dp_vector_pkg::*;
  import dp_alu_ops_pkg::*;

  localparam int wait_limit   = 200;
  localparam int drain_limit  = 4000;
  localparam int stream_count = 200;
  localparam int flush_count  = 20;

  logic        clock;
  logic        clock2x;
  logic        resetn;
  logic        start;
  vector_in_t  in_data;
  logic        in_valid;
  logic        in_stall;
  vector_out_t out_data;
  logic        out_valid;
  logic        out_stall;

  vector_out_t expected[$];
  vector_out_t last_data;
  logic        last_stalled;
  logic        stall_random;
  logic        flushing;

  double_pumped_alu UUT (
    .clock     (clock),
    .clock2x   (clock2x),
    .resetn    (resetn),
    .start     (start),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_stall  (in_stall),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_stall (out_stall)
  );

  // --------------------
  // Clocks, rising edges of clock line up with clock2x

  initial
  begin
    clock = 1'b0;
    #1;
    forever
    begin
      #2;
      clock = ~clock;
    end
  end

  initial
  begin
    clock2x = 1'b0;
    forever
    begin
      #1;
      clock2x = ~clock2x;
    end
  end

  // --------------------
  // Reference model

  function automatic logic [lane_width-1:0] lane_ref(input alu_op_t op, input lane_t l);
    logic [lane_width:0] wide;
    wide = '0;
    case (op)
      op_add:  wide = {1'b0, l.x} + {1'b0, l.y};
      op_sub:  wide = {1'b0, l.x} - {1'b0, l.y};
      op_and:  wide = {1'b0, l.x & l.y};
      op_max:  wide = (l.x >= l.y) ? {1'b0, l.x} : {1'b0, l.y};
      default: wide = '0;
    endcase
    // Upper bit dropped so add and sub wrap
    return wide[lane_width-1:0];
  endfunction

  function automatic vector_out_t ref_alu(input vector_in_t v);
    vector_out_t r;
    r.res0 = lane_ref(v.op, v.lane0);
    r.res1 = lane_ref(v.op, v.lane1);
    return r;
  endfunction

  function automatic vector_in_t make_vector(input alu_op_t op,
                                             input logic [lane_width-1:0] x0,
                                             input logic [lane_width-1:0] y0,
                                             input logic [lane_width-1:0] x1,
                                             input logic [lane_width-1:0] y1);
    vector_in_t v;
    v.op = op;
    v.lane0.x = x0;
    v.lane0.y = y0;
    v.lane1.x = x1;
    v.lane1.y = y1;
    return v;
  endfunction

  function automatic vector_in_t random_vector();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $urandom;
    r1 = $urandom;
    r2 = $urandom;
    return make_vector(alu_op_t'(r2[1:0]), r0[15:0], r0[31:16], r1[15:0], r1[31:16]);
  endfunction

  // --------------------
  // Checks

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_vector(input string name, input vector_out_t got,
                              input vector_out_t exp);
    if (got.res0 !== exp.res0)
      fail_run($sformatf("mismatch %s.res0 got %h expected %h", name, got.res0, exp.res0));
    if (got.res1 !== exp.res1)
      fail_run($sformatf("mismatch %s.res1 got %h expected %h", name, got.res1, exp.res1));
  endtask

  task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  // Accepted vectors, sampled mid-cycle
  always @(negedge clock)
  begin
    if (resetn && in_valid && !in_stall && !start)
      expected.push_back(ref_alu(in_data));
  end

  initial
  begin
    last_stalled = 1'b0;
    last_data = '0;
    forever
    begin
      @(negedge clock);
      if (flushing)
        last_stalled = 1'b0;
      else
      begin
        if (last_stalled)
        begin
          expect_flag("out_valid", out_valid, 1'b1);
          check_vector("out_data", out_data, last_data);
        end
        if (out_valid && !out_stall)
        begin
          if (expected.size() == 0)
            fail_run("a result came out with no vector pending");
          check_vector("out_data", out_data, expected.pop_front());
        end
        last_stalled = out_valid && out_stall;
        last_data = out_data;
      end
    end
  end

  // --------------------
  // Stimulus

  initial
  begin
    out_stall <= 1'b0;
    forever
    begin
      @(posedge clock);
      if (stall_random)
        out_stall <= ($urandom % 3 == 0);
      else
        out_stall <= 1'b0;
    end
  end

  // Called on a rising edge, returns on the edge that takes the vector
  task automatic send_vector(input vector_in_t v);
    int waited;
    waited = 0;
    in_valid <= 1'b1;
    in_data <= v;
    @(negedge clock);
    while (in_stall)
    begin
      waited++;
      if (waited > wait_limit)
        fail_run("timeout waiting for in_stall to drop");
      @(negedge clock);
    end
    @(posedge clock);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (expected.size() != 0)
    begin
      @(posedge clock);
      waited++;
      if (waited > drain_limit)
        fail_run("timeout waiting for pending results to come out");
    end
  endtask

  task automatic run_single(input vector_in_t v);
    send_vector(v);
    in_valid <= 1'b0;
    wait_drained();
  endtask

  initial
  begin
    void'($urandom(46));
    stall_random = 1'b0;
    flushing = 1'b0;
    resetn <= 1'b0;
    start <= 1'b0;
    in_valid <= 1'b0;
    in_data <= '0;
    repeat (2) @(posedge clock);
    resetn <= 1'b1;

    repeat (10)
    begin
      @(negedge clock);
      expect_flag("out_valid", out_valid, 1'b0);
      expect_flag("in_stall", in_stall, 1'b0);
    end
    @(posedge clock);

    run_single(make_vector(op_add, 16'hffff, 16'h0002, 16'h8000, 16'h8000));
    run_single(make_vector(op_sub, 16'h0001, 16'h0003, 16'h1234, 16'h0234));
    run_single(make_vector(op_and, 16'hf0f0, 16'h3c3c, 16'hffff, 16'h0000));
    run_single(make_vector(op_max, 16'h1234, 16'h1234, 16'h8000, 16'h7fff));
    run_single(make_vector(op_max, 16'h0000, 16'hffff, 16'hffff, 16'hffff));

    for (int i = 0; i < stream_count; i++)
      send_vector(random_vector());
    in_valid <= 1'b0;
    wait_drained();

    @(negedge clock);
    stall_random = 1'b1;
    @(posedge clock);
    for (int i = 0; i < stream_count; i++)
      send_vector(random_vector());
    in_valid <= 1'b0;
    wait_drained();
    @(negedge clock);
    stall_random = 1'b0;
    @(posedge clock);

    // -------------------- flush with vectors in flight
    for (int i = 0; i < 6; i++)
      send_vector(random_vector());
    in_valid <= 1'b0;
    start <= 1'b1;
    flushing = 1'b1;
    @(posedge clock);
    start <= 1'b0;
    // Last vector would surface here without the flush
    @(posedge clock);
    expected.delete();
    repeat (10)
    begin
      @(negedge clock);
      expect_flag("out_valid", out_valid, 1'b0);
    end
    @(posedge clock);
    flushing = 1'b0;
    for (int i = 0; i < flush_count; i++)
      send_vector(random_vector());
    in_valid <= 1'b0;
    wait_drained();

    // Quiet cycles so a stray extra result is still seen
    repeat (10) @(posedge clock);
    $display("RESULT: PASS");
    $finish;
  end

  initial
  begin
    #1000000;
    fail_run("simulation ran past its time limit");
  end

endmodule

// ==== list.f ====
hdl/dp_alu_ops_pkg.sv
hdl/dp_vector_pkg.sv
hdl/vector_to_stream.sv
hdl/lane_alu.sv
hdl/stream_to_vector.sv
hdl/double_pumped_alu.sv
test/tb_double_pumped_alu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the double-pumped ALU testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
top=tb_double_pumped_alu

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module "$top" \
  -Mdir "$build_dir" \
  -o "$top" \
  -f list.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

"./$build_dir/$top"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit "$status"
fi

echo "simulation finished cleanly"
exit 0
